/* src/affine_pkg.sv */
`default_nettype none

package affine_pkg;

    localparam int FIX_W     = 16;
    localparam int FRAC_BITS = 8;
    localparam int PROD_W    = 2 * FIX_W;
    localparam int ACC_W     = 36;      // Four Q.16 terms plus headroom
    localparam int LANES     = 3;

    typedef logic signed [FIX_W-1:0]  fix_t;    // Q8.8
    typedef logic signed [PROD_W-1:0] prod_t;   // Q16.16 element product
    typedef logic signed [ACC_W-1:0]  acc_t;    // Q.16 lane sum
    typedef logic        [1:0]        row_idx_t;
    typedef logic        [LANES-1:0]  sat_t;    // One flag per component

    localparam fix_t FIX_ONE    = fix_t'(1 << FRAC_BITS);
    localparam acc_t ROUND_HALF = acc_t'(1 << (FRAC_BITS - 1));

    // Output range of a Q8.8 word
    localparam acc_t SAT_HI     = acc_t'((1 << (FIX_W - 1)) - 1);
    localparam acc_t SAT_LO     = -acc_t'(1 << (FIX_W - 1));

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vec3_t;

    // One matrix row and its translation element
    typedef struct packed {
        fix_t m0;
        fix_t m1;
        fix_t m2;
        fix_t t;
    } mat_row_t;

    typedef struct packed {
        logic     valid;
        mat_row_t row;
        vec3_t    vec;
    } lane_cmd_t;

    typedef struct packed {
        logic valid;
        acc_t sum;
    } lane_sum_t;

    typedef struct packed {
        vec3_t vec;
        sat_t  sat;
    } result_t;

endpackage

`default_nettype wire

/* src/operand_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_loader
    import affine_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      row_we,
    input  row_idx_t  row_sel,
    input  mat_row_t  row_data,
    input  logic      in_valid,
    input  vec3_t     in_vec,
    output lane_cmd_t cmd [LANES]
);

    mat_row_t rows [LANES];     // Live matrix store
    mat_row_t row_q [LANES];    // Rows captured with the vector
    vec3_t    vec_q;
    logic     vec_valid;

    function automatic mat_row_t identity_row(int idx);
        mat_row_t r;
        r    = '0;
        r.m0 = (idx == 0) ? FIX_ONE : '0;
        r.m1 = (idx == 1) ? FIX_ONE : '0;
        r.m2 = (idx == 2) ? FIX_ONE : '0;
        return r;
    endfunction

    // Row writes, visible from the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LANES; i++) begin
                rows[i] <= identity_row(i);
            end
        end else if (row_we && row_sel < row_idx_t'(LANES)) begin
            rows[row_sel] <= row_data;   // Select 3 falls through
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vec_valid <= 1'b0;
        end else begin
            vec_valid <= in_valid;
        end
    end

    // Snapshot of the old rows when a write lands in the same cycle
    always_ff @(posedge clk) begin
        vec_q <= in_vec;
        for (int i = 0; i < LANES; i++) begin
            row_q[i] <= rows[i];
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            cmd[i].valid = vec_valid;
            cmd[i].row   = row_q[i];
            cmd[i].vec   = vec_q;   // Shared by all lanes
        end
    end

endmodule

`default_nettype wire

/* src/row_dot.sv */
`timescale 1ns/1ps
`default_nettype none

module row_dot
    import affine_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  lane_cmd_t cmd,
    output lane_sum_t sum
);

    // Stage one terms, all at Q.16
    typedef struct packed {
        prod_t px;
        prod_t py;
        prod_t pz;
        acc_t  t_term;
    } dot_terms_t;

    dot_terms_t terms;
    logic       s1_valid;
    acc_t       s2_sum;
    logic       s2_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= cmd.valid;
            s2_valid <= s1_valid;
        end
    end

    // Element products and scaled translation
    always_ff @(posedge clk) begin
        terms.px     <= $signed(cmd.row.m0) * $signed(cmd.vec.x);
        terms.py     <= $signed(cmd.row.m1) * $signed(cmd.vec.y);
        terms.pz     <= $signed(cmd.row.m2) * $signed(cmd.vec.z);
        terms.t_term <= acc_t'($signed(cmd.row.t)) <<< FRAC_BITS;
    end

    // Four term sum
    always_ff @(posedge clk) begin
        s2_sum <= acc_t'(terms.px)
                + acc_t'(terms.py)
                + acc_t'(terms.pz)
                + terms.t_term;
    end

    assign sum.valid = s2_valid;
    assign sum.sum   = s2_sum;

endmodule

`default_nettype wire

/* src/result_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_packer
    import affine_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  lane_sum_t sums [LANES],
    output logic      out_valid,
    output result_t   out_result
);

    fix_t  comp [LANES];    // Rounded, clamped components
    sat_t  clamp;
    vec3_t vec_d;
    vec3_t vec_q;
    sat_t  sat_q;

    // Round half up, drop fraction, clamp to Q8.8
    always_comb begin
        acc_t rounded;
        acc_t shifted;
        for (int k = 0; k < LANES; k++) begin
            rounded  = sums[k].sum + ROUND_HALF;
            shifted  = rounded >>> FRAC_BITS;
            clamp[k] = 1'b0;
            if (shifted > SAT_HI) begin
                comp[k]  = fix_t'(SAT_HI);
                clamp[k] = 1'b1;
            end else if (shifted < SAT_LO) begin
                comp[k]  = fix_t'(SAT_LO);
                clamp[k] = 1'b1;
            end else begin
                comp[k]  = fix_t'(shifted);
            end
        end
    end

    assign vec_d.x = comp[0];
    assign vec_d.y = comp[1];
    assign vec_d.z = comp[2];

    // Lane 0 valid stands for all three
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            sat_q     <= '0;
        end else begin
            out_valid <= sums[0].valid;
            sat_q     <= sums[0].valid ? clamp : '0;   // No flags without data
        end
    end

    always_ff @(posedge clk) begin
        vec_q <= vec_d;
    end

    assign out_result.vec = vec_q;
    assign out_result.sat = sat_q;

endmodule

`default_nettype wire

/* src/affine_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module affine_unit
    import affine_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Matrix row writes
    input  logic     row_we,
    input  row_idx_t row_sel,
    input  mat_row_t row_data,

    // Vector stream
    input  logic     in_valid,
    input  vec3_t    in_vec,
    output logic     out_valid,
    output result_t  out_result
);

    lane_cmd_t cmd  [LANES];
    lane_sum_t sums [LANES];

    operand_loader u_operand_loader (
        .clk      (clk),
        .reset    (reset),
        .row_we   (row_we),
        .row_sel  (row_sel),
        .row_data (row_data),
        .in_valid (in_valid),
        .in_vec   (in_vec),
        .cmd      (cmd)
    );

    // One lane per output component
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        row_dot u_row_dot (
            .clk   (clk),
            .reset (reset),
            .cmd   (cmd[i]),
            .sum   (sums[i])
        );
    end

    result_packer u_result_packer (
        .clk        (clk),
        .reset      (reset),
        .sums       (sums),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

/* tb/affine_unit_props.sv */
`timescale 1ns/1ps
`default_nettype none

module affine_unit_props
    import affine_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    in_valid,
    input logic    out_valid,
    input result_t out_result
);

    // Reset clears the output strobe by the next edge
    property p_idle_after_reset;
        @(posedge clk) reset |=> !out_valid;
    endproperty

    // Sampled values, so the pipeline shows up as four edges here
    property p_fixed_latency;
        @(posedge clk) disable iff (reset)
            (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3) && !$past(reset, 4))
            |-> (out_valid == $past(in_valid, 4));
    endproperty

    property p_no_flags_when_idle;
        @(posedge clk) disable iff (reset)
            !out_valid |-> (out_result.sat == '0);
    endproperty

    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("out_valid high in the cycle after reset");

    a_fixed_latency: assert property (p_fixed_latency)
        else $error("out_valid does not follow in_valid by the pipeline depth");

    a_no_flags_when_idle: assert property (p_no_flags_when_idle)
        else $error("sat flags set while out_valid is low");

endmodule

bind affine_unit affine_unit_props u_affine_unit_props (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_result (out_result)
);

`default_nettype wire

/* tb/affine_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module affine_unit_tb
    import affine_pkg::*;
();

    localparam int CLK_PERIOD       = 10;
    localparam int LATENCY          = 3;    // Edges from sampling edge to out_valid
    localparam int RAND_VECS        = 60;
    localparam int RAND_WRITE_EVERY = 12;
    localparam int RAND_STEPS       = RAND_VECS
                                    + (RAND_VECS + RAND_WRITE_EVERY - 1) / RAND_WRITE_EVERY;
    localparam logic [15:0] LFSR_SEED = 16'd12;

    // One table row, a reset, a row write, a vector or a mix of them
    typedef struct packed {
        logic     rst;
        logic     we;
        row_idx_t sel;
        mat_row_t row;
        logic     vv;
        vec3_t    vec;
        logic     has_exp;    // Hand-derived result in want
        result_t  want;
    } step_t;

    typedef struct packed {
        result_t res;
        int      due;
    } pending_t;

    logic     clk;
    logic     reset;
    logic     row_we;
    row_idx_t row_sel;
    mat_row_t row_data;
    logic     in_valid;
    vec3_t    in_vec;
    logic     out_valid;
    result_t  out_result;

    step_t       steps [$];
    pending_t    exp_q [$];
    mat_row_t    model_rows [LANES];
    logic [15:0] lfsr_state;
    logic        table_ready = 1'b0;
    int          cycle = 0;

    affine_unit u_affine_unit (
        .clk        (clk),
        .reset      (reset),
        .row_we     (row_we),
        .row_sel    (row_sel),
        .row_data   (row_data),
        .in_valid   (in_valid),
        .in_vec     (in_vec),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic fix_t rand_fix(int n);
        logic [15:0] w;
        w = rand_bits(n);
        if (n < 16 && w[n-1]) begin
            w = w | ~((16'd1 << n) - 16'd1);   // Sign extend
        end
        return fix_t'(w);
    endfunction

    task automatic model_reset();
        model_rows[0] = {16'h0100, 16'h0000, 16'h0000, 16'h0000};
        model_rows[1] = {16'h0000, 16'h0100, 16'h0000, 16'h0000};
        model_rows[2] = {16'h0000, 16'h0000, 16'h0100, 16'h0000};
    endtask

    // Sum at full precision, round half up, drop 8 bits, clamp
    function automatic result_t model_result(vec3_t v);
        result_t r;
        longint  acc;
        fix_t    f;
        r = '0;
        for (int k = 0; k < LANES; k++) begin
            acc = longint'(model_rows[k].m0) * longint'(v.x)
                + longint'(model_rows[k].m1) * longint'(v.y)
                + longint'(model_rows[k].m2) * longint'(v.z)
                + longint'(model_rows[k].t) * 256;
            acc = (acc + 128) >>> 8;
            if (acc > 32767) begin
                f = 16'h7FFF;
                r.sat[k] = 1'b1;
            end else if (acc < -32768) begin
                f = 16'h8000;
                r.sat[k] = 1'b1;
            end else begin
                f = fix_t'(acc);
            end
            case (k)
                0:       r.vec.x = f;
                1:       r.vec.y = f;
                default: r.vec.z = f;
            endcase
        end
        return r;
    endfunction

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_output();
        pending_t p;
        if (out_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Output appeared at %0t with no vector in flight", $time);
                report_failure();
            end
            p = exp_q.pop_front();
            assert (p.due == cycle) else begin
                $display("ERROR %0t: output at cycle %0d, expected at cycle %0d",
                         $time, cycle, p.due);
                report_failure();
            end
            assert (out_result == p.res) else begin
                $display("ERROR %0t: got x=%h y=%h z=%h sat=%b, expected x=%h y=%h z=%h sat=%b",
                         $time, out_result.vec.x, out_result.vec.y, out_result.vec.z,
                         out_result.sat, p.res.vec.x, p.res.vec.y, p.res.vec.z, p.res.sat);
                report_failure();
            end
        end else if (exp_q.size() > 0) begin
            assert (exp_q[0].due > cycle) else begin
                $display("Output missing at %0t, it was due at cycle %0d", $time, exp_q[0].due);
                report_failure();
            end
        end
    endtask

    // Check what the last edge produced, then drive the next inputs
    task automatic apply_step(step_t s);
        pending_t p;
        @(negedge clk);
        check_output();
        reset    = s.rst;
        row_we   = s.we;
        row_sel  = s.sel;
        row_data = s.row;
        in_valid = s.vv;
        in_vec   = s.vec;
        if (s.rst) begin
            exp_q.delete();     // In-flight vectors are lost
            model_reset();
        end else begin
            if (s.vv) begin
                p.res = s.has_exp ? s.want : model_result(s.vec);
                p.due = cycle + 1 + LATENCY;
                exp_q.push_back(p);
            end
            if (s.we && s.sel < row_idx_t'(LANES)) begin
                model_rows[s.sel] = s.row;    // After the vector, which sees the old row
            end
        end
    endtask

    task automatic add_write(row_idx_t sel, mat_row_t row);
        step_t s;
        s = '0;
        s.we  = 1'b1;
        s.sel = sel;
        s.row = row;
        steps.push_back(s);
    endtask

    task automatic add_vec(vec3_t v);
        step_t s;
        s = '0;
        s.vv  = 1'b1;
        s.vec = v;
        steps.push_back(s);
    endtask

    task automatic add_both(row_idx_t sel, mat_row_t row, vec3_t v);
        step_t s;
        s = '0;
        s.we  = 1'b1;
        s.sel = sel;
        s.row = row;
        s.vv  = 1'b1;
        s.vec = v;
        steps.push_back(s);
    endtask

    task automatic add_check(vec3_t v, vec3_t want, sat_t sat);
        step_t s;
        s = '0;
        s.vv       = 1'b1;
        s.vec      = v;
        s.has_exp  = 1'b1;
        s.want.vec = want;
        s.want.sat = sat;
        steps.push_back(s);
    endtask

    task automatic add_reset();
        step_t s;
        s = '0;
        s.rst = 1'b1;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Identity after reset
        add_check({16'h0100, 16'hFF00, 16'h1234}, {16'h0100, 16'hFF00, 16'h1234}, 3'b000);
        add_check({16'h7FFF, 16'h8000, 16'h0001}, {16'h7FFF, 16'h8000, 16'h0001}, 3'b000);
        add_vec({16'hFEDC, 16'h0042, 16'h8001});
        steps.push_back('0);
        // Fractional and negative entries, half LSB cases on row 2
        add_write(2'd0, {16'h0180, 16'hFF80, 16'h0040, 16'h0100});
        add_write(2'd1, {16'h0000, 16'h0200, 16'h0000, 16'hFE80});
        add_write(2'd2, {16'h0001, 16'h0001, 16'h0001, 16'h0000});
        add_check({16'h0200, 16'h0100, 16'h0400}, {16'h0480, 16'h0080, 16'h0007}, 3'b000);
        add_check({16'h0080, 16'h0000, 16'h0000}, {16'h01C0, 16'hFE80, 16'h0001}, 3'b000);
        add_check({16'hFF80, 16'h0000, 16'h0000}, {16'h0040, 16'hFE80, 16'h0000}, 3'b000);
        add_vec({16'hF3A0, 16'h0C35, 16'hFFFF});
        add_vec({16'h0001, 16'hFFFF, 16'h0080});
        // Saturation high and low
        add_write(2'd0, {16'h7FFF, 16'h0000, 16'h0000, 16'h7FFF});
        add_write(2'd1, {16'h8000, 16'h0000, 16'h0000, 16'h0000});
        add_write(2'd2, {16'h0100, 16'h0000, 16'h0000, 16'h0000});
        add_check({16'h7FFF, 16'h0000, 16'h0000}, {16'h7FFF, 16'h8000, 16'h7FFF}, 3'b011);
        add_check({16'h0100, 16'h0000, 16'h0000}, {16'h7FFF, 16'h8000, 16'h0100}, 3'b001);
        add_vec({16'h8000, 16'h1234, 16'h4321});
        // Back to back with a write in the middle
        add_write(2'd1, {16'h0100, 16'h0100, 16'h0100, 16'h0010});
        add_vec({16'h0100, 16'h0200, 16'h0300});
        add_vec({16'hFF00, 16'h0080, 16'h0040});
        add_both(2'd1, {16'hFF00, 16'h0080, 16'h0000, 16'h0200}, {16'h0010, 16'h0020, 16'h0030});
        add_vec({16'h0010, 16'h0020, 16'h0030});
        add_vec({16'h1000, 16'hF000, 16'h0001});
        // Row select 3 is ignored
        add_write(2'd3, {16'h1111, 16'h2222, 16'h3333, 16'h4444});
        add_vec({16'h0123, 16'h0456, 16'h0789});
        // Reset in mid stream, then identity again
        add_vec({16'h0100, 16'h0100, 16'h0100});
        add_vec({16'h0200, 16'h0200, 16'h0200});
        add_reset();
        add_reset();
        add_write(2'd3, {16'h1111, 16'h2222, 16'h3333, 16'h4444});
        add_check({16'h0ABC, 16'hF123, 16'h0055}, {16'h0ABC, 16'hF123, 16'h0055}, 3'b000);
        add_check({16'h8000, 16'h7FFF, 16'h0000}, {16'h8000, 16'h7FFF, 16'h0000}, 3'b000);
    endtask

    task automatic run_random();
        step_t s;
        for (int i = 0; i < RAND_VECS; i++) begin
            if (i % RAND_WRITE_EVERY == 0) begin
                s = '0;
                s.we  = 1'b1;
                s.sel = row_idx_t'(rand_bits(2));
                s.row = {rand_fix(11), rand_fix(11), rand_fix(11), rand_fix(11)};
                apply_step(s);
            end
            s = '0;
            s.vv  = 1'b1;
            s.vec = {rand_fix(14), rand_fix(14), rand_fix(14)};
            apply_step(s);
        end
    endtask

    initial begin
        step_t idle;
        reset      = 1'b1;
        row_we     = 1'b0;
        row_sel    = '0;
        row_data   = '0;
        in_valid   = 1'b0;
        in_vec     = '0;
        idle       = '0;
        lfsr_state = LFSR_SEED;
        build_table();
        model_reset();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        run_random();
        repeat (LATENCY + 3) apply_step(idle);
        assert (exp_q.size() == 0) else begin
            $display("Outputs still pending at the end of the run");
            report_failure();
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (steps.size() + RAND_STEPS + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout, the run did not finish within %0d ns", limit_ns);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* sources.f */
src/affine_pkg.sv
src/operand_loader.sv
src/row_dot.sv
src/result_packer.sv
src/affine_unit.sv
tb/affine_unit_props.sv
tb/affine_unit_tb.sv

/* Makefile */
# Verilator simulation of the affine transform unit

VERILATOR ?= verilator
TOP       ?= affine_unit_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
